// File: sms_pkg.sv
package sms_pkg;

  // ========================================
  // Width types
  // ========================================
  typedef logic [15:0] cpu_addr_t;
  typedef logic [7:0]  cpu_data_t;
  typedef logic [13:0] vram_addr_t;   // 16K VDP memory pointer
  typedef logic [23:0] ext_addr_t;    // Translated memory address
  typedef logic [7:0]  bank_t;
  typedef logic [3:0]  vdp_reg_idx_t;

  // ========================================
  // Enums
  // ========================================
  typedef enum logic [2:0] {
    ACC_MEM,
    ACC_VDP_DATA,
    ACC_VDP_CTRL,
    ACC_JOY0,
    ACC_JOY1,
    ACC_MEM_CTRL,
    ACC_IO_OTHER    // PSG, H/V counters, joypad control
  } access_e;

  typedef enum logic [1:0] {
    TGT_BIOS,
    TGT_CART,
    TGT_RAM
  } mem_target_e;

  // Two-byte control port sequence
  typedef enum logic {
    CTRL_FIRST_BYTE,
    CTRL_SECOND_BYTE
  } ctrl_state_e;

  // ========================================
  // Constants
  // ========================================
  localparam int VDP_REG_COUNT = 11;
  localparam int CRAM_DEPTH    = 32;
  localparam int VRAM_DEPTH    = 16384;

  localparam cpu_data_t  MEM_CTRL_RESET  = 8'hF7;  // BIOS enabled
  localparam bank_t      SLOT0_RESET     = 8'd0;
  localparam bank_t      SLOT1_RESET     = 8'd1;
  localparam bank_t      SLOT2_RESET     = 8'd2;
  localparam cpu_addr_t  SLOT_REG_BASE   = 16'hFFFD;
  localparam logic [1:0] RAM_REGION      = 2'd3;   // C000 and above
  localparam cpu_data_t  OPEN_BUS        = 8'hFF;
  localparam cpu_data_t  JOY1_IDLE       = 8'hBF;
  localparam logic [4:0] STATUS_LOW_IDLE = 5'b11111;
  localparam int         BIOS_SELECT_BIT = 3;

endpackage

// File: sms_access_if.sv
`timescale 1ns/10ps

// One decoded CPU access, from decode to both execute modules
interface sms_access_if
  import sms_pkg::*;
();
  logic      acc_valid;
  access_e   acc_kind;
  logic      acc_wr;
  cpu_addr_t acc_addr;
  cpu_data_t acc_wdata;

  modport decode (
    output acc_valid,
    output acc_kind,
    output acc_wr,
    output acc_addr,
    output acc_wdata
  );

  modport execute (
    input acc_valid,
    input acc_kind,
    input acc_wr,
    input acc_addr,
    input acc_wdata
  );
endinterface

// File: sms_exec_if.sv
`timescale 1ns/10ps

// Executed mapper/IO result, one cycle after the access
interface sms_exec_if
  import sms_pkg::*;
();
  logic        ex_valid;       // Access has an output (memory or IO read)
  access_e     ex_kind;
  cpu_data_t   ex_rdata;
  mem_target_e ex_mem_target;
  ext_addr_t   ex_mem_addr;
  logic        ex_mem_we;

  modport execute (
    output ex_valid,
    output ex_kind,
    output ex_rdata,
    output ex_mem_target,
    output ex_mem_addr,
    output ex_mem_we
  );

  modport result (
    input ex_valid,
    input ex_kind,
    input ex_rdata,
    input ex_mem_target,
    input ex_mem_addr,
    input ex_mem_we
  );
endinterface

// File: sms_port_decode.sv
`timescale 1ns/10ps

module sms_port_decode
  import sms_pkg::*;
(
  input  logic         i_clk,
  input  logic         n_hard_reset,
  input  logic         i_bus_valid,
  input  cpu_addr_t    i_addr,
  input  cpu_data_t    i_wdata,
  input  logic         i_wr,
  input  logic         i_iorq,
  sms_access_if.decode acc
);

  access_e kind;

  // ========================================
  // Port classification
  // ========================================
  always_comb begin
    if (!i_iorq) begin
      kind = ACC_MEM;
    end else begin
      case (i_addr[7:6])
        2'd2: begin
          kind = i_addr[0] ? ACC_VDP_CTRL : ACC_VDP_DATA;
        end
        2'd3: begin
          kind = i_addr[0] ? ACC_JOY1 : ACC_JOY0;
        end
        2'd0: begin
          // Odd address is joypad control, not kept
          kind = i_addr[0] ? ACC_IO_OTHER : ACC_MEM_CTRL;
        end
        default: begin
          kind = ACC_IO_OTHER;  // PSG and H/V counters
        end
      endcase
    end
  end

  // ========================================
  // Decode register
  // ========================================
  always_ff @(posedge i_clk) begin
    if (!n_hard_reset) begin
      acc.acc_valid <= 1'b0;
    end else begin
      acc.acc_valid <= i_bus_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    acc.acc_kind  <= kind;
    acc.acc_wr    <= i_wr;
    acc.acc_addr  <= i_addr;
    acc.acc_wdata <= i_wdata;
  end

endmodule

// File: sms_vdp_port.sv
`timescale 1ns/10ps

module sms_vdp_port
  import sms_pkg::*;
(
  input  logic          i_clk,
  input  logic          n_hard_reset,
  sms_access_if.execute acc,
  input  logic          i_frame_irq,
  input  logic          i_sprite_hit,
  output cpu_data_t     o_vdp_rdata,
  output logic          o_n_int,
  output logic [2:0]    o_video_mode
);

  cpu_data_t    vram [VRAM_DEPTH];
  cpu_data_t    cram [CRAM_DEPTH];
  cpu_data_t    vdp_regs [VDP_REG_COUNT];
  vram_addr_t   vdp_addr;
  cpu_data_t    addr_latch;      // First control byte
  ctrl_state_e  ctrl_state;
  logic         cram_sel;
  logic         frame_flag;
  logic         coll_flag;
  cpu_data_t    vram_q;
  cpu_data_t    cram_q;
  cpu_data_t    status_q;
  logic         rd_status_q;
  logic         rd_cram_q;
  vdp_reg_idx_t reg_idx;
  logic         ctrl_wr;
  logic         ctrl_rd;
  logic         data_acc;
  logic         data_wr;

  assign ctrl_wr  = acc.acc_valid && acc.acc_kind == ACC_VDP_CTRL && acc.acc_wr;
  assign ctrl_rd  = acc.acc_valid && acc.acc_kind == ACC_VDP_CTRL && !acc.acc_wr;
  assign data_acc = acc.acc_valid && acc.acc_kind == ACC_VDP_DATA;
  assign data_wr  = data_acc && acc.acc_wr;
  assign reg_idx  = acc.acc_wdata[3:0];

  // ========================================
  // Control port FSM and registers
  // ========================================
  always_ff @(posedge i_clk) begin
    if (!n_hard_reset) begin
      ctrl_state <= CTRL_FIRST_BYTE;
      vdp_addr   <= '0;
      cram_sel   <= 1'b0;
      for (int i = 0; i < VDP_REG_COUNT; i++) begin
        vdp_regs[i] <= '0;
      end
    end else begin
      // Status read or data access restarts the byte pair
      if (ctrl_rd || data_acc) begin
        ctrl_state <= CTRL_FIRST_BYTE;
      end
      if (data_acc) begin
        vdp_addr <= vdp_addr + 1'b1;  // Auto-increment
      end
      if (ctrl_wr) begin
        if (ctrl_state == CTRL_FIRST_BYTE) begin
          addr_latch <= acc.acc_wdata;
          ctrl_state <= CTRL_SECOND_BYTE;
        end else begin
          ctrl_state <= CTRL_FIRST_BYTE;
          if (!acc.acc_wdata[7]) begin
            // VRAM address, bit 6 read/write hint ignored
            vdp_addr <= {acc.acc_wdata[5:0], addr_latch};
            cram_sel <= 1'b0;
          end else if (!acc.acc_wdata[6] && reg_idx < VDP_REG_COUNT) begin
            vdp_regs[reg_idx] <= addr_latch;
          end else begin
            vdp_addr <= {8'd0, addr_latch[5:0]};
            cram_sel <= 1'b1;
          end
        end
      end
    end
  end

  // ========================================
  // VRAM and CRAM
  // ========================================
  always_ff @(posedge i_clk) begin
    if (data_wr && !cram_sel) begin
      vram[vdp_addr] <= acc.acc_wdata;
    end
    vram_q <= vram[vdp_addr];
  end

  always_ff @(posedge i_clk) begin
    if (data_wr && cram_sel) begin
      cram[vdp_addr[4:0]] <= acc.acc_wdata;
    end
    cram_q <= cram[vdp_addr[4:0]];
  end

  // Sticky flags, a new event beats the status-read clear
  always_ff @(posedge i_clk) begin
    if (!n_hard_reset) begin
      frame_flag <= 1'b0;
      coll_flag  <= 1'b0;
    end else begin
      if (ctrl_rd) begin
        frame_flag <= 1'b0;
        coll_flag  <= 1'b0;
      end
      if (i_frame_irq) begin
        frame_flag <= 1'b1;
      end
      if (i_sprite_hit) begin
        coll_flag <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    status_q    <= {frame_flag, 1'b0, coll_flag, STATUS_LOW_IDLE};
    rd_status_q <= ctrl_rd;
    rd_cram_q   <= cram_sel;   // Selection seen by this data access
  end

  assign o_vdp_rdata = rd_status_q ? status_q : (rd_cram_q ? cram_q : vram_q);

  assign o_n_int = !(frame_flag && vdp_regs[1][5]);

  // Mode priority M4 > M3 > M2 > M1
  always_comb begin
    if (vdp_regs[0][2]) begin
      o_video_mode = 3'd4;
    end else if (vdp_regs[1][3]) begin
      o_video_mode = 3'd3;
    end else if (vdp_regs[0][1]) begin
      o_video_mode = 3'd2;
    end else if (vdp_regs[1][4]) begin
      o_video_mode = 3'd1;
    end else begin
      o_video_mode = 3'd0;
    end
  end

endmodule

// File: sms_mapper_regs.sv
`timescale 1ns/10ps

module sms_mapper_regs
  import sms_pkg::*;
(
  input  logic          i_clk,
  input  logic          n_hard_reset,
  sms_access_if.execute acc,
  input  logic [6:0]    i_buttons,
  sms_exec_if.execute   ex
);

  bank_t       slot [3];
  cpu_data_t   mem_ctrl;
  logic [1:0]  region;
  logic        mem_wr;
  mem_target_e target;
  ext_addr_t   xlat_addr;
  cpu_data_t   io_rdata;

  assign region = acc.acc_addr[15:14];
  assign mem_wr = acc.acc_valid && acc.acc_kind == ACC_MEM && acc.acc_wr;

  // ========================================
  // Memory routing
  // ========================================
  always_comb begin
    if (region == RAM_REGION) begin
      target    = TGT_RAM;
      xlat_addr = {11'd0, acc.acc_addr[12:0]};  // 8K mirrored
    end else if (!mem_ctrl[BIOS_SELECT_BIT]) begin
      target    = TGT_BIOS;
      xlat_addr = {10'd0, acc.acc_addr[13:0]};
    end else begin
      target    = TGT_CART;
      xlat_addr = {2'd0, slot[region], acc.acc_addr[13:0]};
    end
  end

  always_comb begin
    case (acc.acc_kind)
      ACC_JOY0: io_rdata = {2'b11, ~i_buttons[2:1], ~i_buttons[6:3]};
      ACC_JOY1: io_rdata = JOY1_IDLE;
      default:  io_rdata = OPEN_BUS;
    endcase
  end

  // Slot and memory-control registers
  always_ff @(posedge i_clk) begin
    if (!n_hard_reset) begin
      mem_ctrl <= MEM_CTRL_RESET;
      slot[0]  <= SLOT0_RESET;
      slot[1]  <= SLOT1_RESET;
      slot[2]  <= SLOT2_RESET;
    end else begin
      if (acc.acc_valid && acc.acc_kind == ACC_MEM_CTRL && acc.acc_wr) begin
        mem_ctrl <= acc.acc_wdata;
      end
      if (mem_wr && acc.acc_addr >= SLOT_REG_BASE) begin
        case (acc.acc_addr[1:0])
          2'd1:    slot[0] <= acc.acc_wdata;
          2'd2:    slot[1] <= acc.acc_wdata;
          default: slot[2] <= acc.acc_wdata;
        endcase
      end
    end
  end

  // ========================================
  // Execute stage outputs
  // ========================================
  always_ff @(posedge i_clk) begin
    if (!n_hard_reset) begin
      ex.ex_valid  <= 1'b0;
      ex.ex_mem_we <= 1'b0;
    end else begin
      // IO writes end here
      ex.ex_valid  <= acc.acc_valid && (acc.acc_kind == ACC_MEM || !acc.acc_wr);
      ex.ex_mem_we <= mem_wr && target == TGT_RAM;
    end
  end

  always_ff @(posedge i_clk) begin
    ex.ex_kind       <= acc.acc_kind;
    ex.ex_rdata      <= io_rdata;
    ex.ex_mem_target <= target;
    ex.ex_mem_addr   <= xlat_addr;
  end

endmodule

// File: sms_bus_result.sv
`timescale 1ns/10ps

module sms_bus_result
  import sms_pkg::*;
(
  input  logic        i_clk,
  input  logic        n_hard_reset,
  sms_exec_if.result  ex,
  input  cpu_data_t   i_vdp_rdata,
  output logic        o_rd_valid,
  output cpu_data_t   o_rd_data,
  output logic        o_mem_valid,
  output logic        o_mem_we,
  output mem_target_e o_mem_target,
  output ext_addr_t   o_mem_addr
);

  logic      is_mem;
  logic      is_vdp;
  cpu_data_t rd_mux;

  assign is_mem = ex.ex_kind == ACC_MEM;
  assign is_vdp = ex.ex_kind == ACC_VDP_DATA || ex.ex_kind == ACC_VDP_CTRL;
  assign rd_mux = is_vdp ? i_vdp_rdata : ex.ex_rdata;  // Read source by port

  // ========================================
  // Output registers
  // ========================================
  always_ff @(posedge i_clk) begin
    if (!n_hard_reset) begin
      o_rd_valid  <= 1'b0;
      o_mem_valid <= 1'b0;
      o_mem_we    <= 1'b0;
    end else begin
      o_rd_valid  <= ex.ex_valid && !is_mem;  // ex_valid is already reads only for IO
      o_mem_valid <= ex.ex_valid && is_mem;
      o_mem_we    <= ex.ex_valid && ex.ex_mem_we;
    end
  end

  always_ff @(posedge i_clk) begin
    o_rd_data    <= rd_mux;
    o_mem_target <= ex.ex_mem_target;
    o_mem_addr   <= ex.ex_mem_addr;
  end

endmodule

// File: sms_system_bus.sv
`timescale 1ns/10ps

module sms_system_bus
  import sms_pkg::*;
(
  input  logic        cpuClock,
  input  logic        n_hard_reset,
  // CPU bus
  input  logic        i_bus_valid,
  input  cpu_addr_t   i_addr,
  input  cpu_data_t   i_wdata,
  input  logic        i_wr,
  input  logic        i_iorq,
  // Video events and buttons
  input  logic        i_frame_irq,
  input  logic        i_sprite_hit,
  input  logic [6:0]  i_buttons,
  // Results
  output logic        o_rd_valid,
  output cpu_data_t   o_rd_data,
  output logic        o_mem_valid,
  output logic        o_mem_we,
  output mem_target_e o_mem_target,
  output ext_addr_t   o_mem_addr,
  output logic        o_n_int,
  output logic [2:0]  o_video_mode
);

  cpu_data_t vdp_rdata;

  sms_access_if acc_bus ();
  sms_exec_if   ex_bus ();

  sms_port_decode u_decode (
    .i_clk        (cpuClock),
    .n_hard_reset (n_hard_reset),
    .i_bus_valid  (i_bus_valid),
    .i_addr       (i_addr),
    .i_wdata      (i_wdata),
    .i_wr         (i_wr),
    .i_iorq       (i_iorq),
    .acc          (acc_bus.decode)
  );

  sms_vdp_port u_vdp (
    .i_clk        (cpuClock),
    .n_hard_reset (n_hard_reset),
    .acc          (acc_bus.execute),
    .i_frame_irq  (i_frame_irq),
    .i_sprite_hit (i_sprite_hit),
    .o_vdp_rdata  (vdp_rdata),
    .o_n_int      (o_n_int),
    .o_video_mode (o_video_mode)
  );

  sms_mapper_regs u_mapper (
    .i_clk        (cpuClock),
    .n_hard_reset (n_hard_reset),
    .acc          (acc_bus.execute),
    .i_buttons    (i_buttons),
    .ex           (ex_bus.execute)
  );

  sms_bus_result u_result (
    .i_clk        (cpuClock),
    .n_hard_reset (n_hard_reset),
    .ex           (ex_bus.result),
    .i_vdp_rdata  (vdp_rdata),
    .o_rd_valid   (o_rd_valid),
    .o_rd_data    (o_rd_data),
    .o_mem_valid  (o_mem_valid),
    .o_mem_we     (o_mem_we),
    .o_mem_target (o_mem_target),
    .o_mem_addr   (o_mem_addr)
  );

endmodule

// File: sms_system_bus_props.sv
`timescale 1ns/10ps

module sms_system_bus_props
  import sms_pkg::*;
(
  input logic        cpuClock,
  input logic        n_hard_reset,
  input logic        o_rd_valid,
  input logic        o_mem_valid,
  input logic        o_mem_we,
  input mem_target_e o_mem_target
);

  // ========================================
  // Output protocol
  // ========================================
  a_one_valid: assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
    !(o_rd_valid && o_mem_valid))
    else $error("o_rd_valid and o_mem_valid high together");

  a_we_with_valid: assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
    o_mem_we |-> o_mem_valid)
    else $error("o_mem_we without o_mem_valid");

  a_we_ram_only: assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
    o_mem_we |-> o_mem_target == TGT_RAM)
    else $error("o_mem_we with a non-RAM target");

  // Synchronous reset clears the valids on the next edge
  a_reset_idle: assert property (@(posedge cpuClock)
    !n_hard_reset |=> !o_rd_valid && !o_mem_valid && !o_mem_we)
    else $error("Valid output after reset");

endmodule

// File: tb_sms_system_bus.sv
`timescale 1ns/10ps

module tb_sms_system_bus
  import sms_pkg::*;
();

  logic        cpuClock;
  logic        n_hard_reset;
  logic        i_bus_valid;
  cpu_addr_t   i_addr;
  cpu_data_t   i_wdata;
  logic        i_wr;
  logic        i_iorq;
  logic        i_frame_irq;
  logic        i_sprite_hit;
  logic [6:0]  i_buttons;
  logic        o_rd_valid;
  cpu_data_t   o_rd_data;
  logic        o_mem_valid;
  logic        o_mem_we;
  mem_target_e o_mem_target;
  ext_addr_t   o_mem_addr;
  logic        o_n_int;
  logic [2:0]  o_video_mode;

  // Reference model state
  cpu_data_t   m_vram [VRAM_DEPTH];
  cpu_data_t   m_cram [CRAM_DEPTH];
  cpu_data_t   m_regs [VDP_REG_COUNT];
  bank_t       m_slot [3];
  vram_addr_t  m_addr;
  cpu_data_t   m_latch;
  cpu_data_t   m_mem_ctrl;
  logic        m_second;     // Next control write completes a pair
  logic        m_cram_sel;
  logic        m_frame;
  logic        m_coll;

  logic [31:0] exp_q [$];    // {mem, 4'b0, we, target, addr} or read byte
  string       name_q [$];
  string       test_name;
  logic [31:0] lfsr_state = 32'haa32;

  sms_system_bus DUT (.*);

  bind sms_system_bus sms_system_bus_props u_props (.*);

  initial begin
    cpuClock = 1'b0;
    forever #4 cpuClock = ~cpuClock;
  end

  // ========================================
  // Random source and helpers
  // ========================================
  function automatic logic [31:0] next_lfsr(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = next_lfsr(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic cpu_data_t rand_byte();
    return cpu_data_t'(rand_bits(8));
  endfunction

  // Port select in bits 7:6 and random other bits
  function automatic cpu_addr_t io_addr(logic [1:0] sel, logic b0);
    logic [31:0] r;
    r = rand_bits(13);
    return {r[12:5], sel, r[4:0], b0};
  endfunction

  function automatic cpu_addr_t low_addr();
    cpu_addr_t a;
    a = cpu_addr_t'(rand_bits(16));
    if (a[15:14] == 2'd3) begin
      a[15] = 1'b0;  // Keep below C000
    end
    return a;
  endfunction

  function automatic cpu_data_t fill_byte(int a, cpu_data_t salt);
    return a[7:0] ^ a[13:6] ^ salt;
  endfunction

  function automatic logic [2:0] model_mode();
    if (m_regs[0][2]) return 3'd4;
    if (m_regs[1][3]) return 3'd3;
    if (m_regs[0][1]) return 3'd2;
    if (m_regs[1][4]) return 3'd1;
    return 3'd0;
  endfunction

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      $display("Result: FAILED");
      $fatal(1, "Value mismatch in %s", name);
    end
  endtask

  task automatic expect_rd(cpu_data_t data);
    exp_q.push_back({24'd0, data});
    name_q.push_back(test_name);
  endtask

  task automatic expect_mem(logic we, mem_target_e tgt, ext_addr_t addr);
    exp_q.push_back({1'b1, 4'd0, we, tgt, addr});
    name_q.push_back(test_name);
  endtask

  // ========================================
  // Reference model
  // ========================================
  task automatic vdp_ctrl(logic wr, cpu_data_t d);
    if (!wr) begin
      expect_rd({m_frame, 1'b0, m_coll, 5'b11111});
      m_frame  = 1'b0;
      m_coll   = 1'b0;
      m_second = 1'b0;
    end else if (!m_second) begin
      m_latch  = d;
      m_second = 1'b1;
    end else begin
      m_second = 1'b0;
      if (!d[7]) begin
        m_addr     = {d[5:0], m_latch};
        m_cram_sel = 1'b0;
      end else if (d[7:6] == 2'b10 && d[3:0] < VDP_REG_COUNT) begin
        m_regs[d[3:0]] = m_latch;
      end else begin
        m_addr     = {8'd0, m_latch[5:0]};
        m_cram_sel = 1'b1;
      end
    end
  endtask

  task automatic vdp_data(logic wr, cpu_data_t d);
    if (!wr) begin
      expect_rd(m_cram_sel ? m_cram[m_addr[4:0]] : m_vram[m_addr]);
    end else if (m_cram_sel) begin
      m_cram[m_addr[4:0]] = d;
    end else begin
      m_vram[m_addr] = d;
    end
    m_addr   = m_addr + 1'b1;
    m_second = 1'b0;
  endtask

  task automatic model_apply(logic iorq, logic wr, cpu_addr_t a, cpu_data_t d);
    mem_target_e tgt;
    ext_addr_t   xa;
    if (!iorq) begin
      if (a[15:14] == 2'd3) begin
        tgt = TGT_RAM;
        xa  = {11'd0, a[12:0]};
      end else if (!m_mem_ctrl[3]) begin
        tgt = TGT_BIOS;
        xa  = {10'd0, a[13:0]};
      end else begin
        tgt = TGT_CART;
        xa  = {2'd0, m_slot[a[15:14]], a[13:0]};
      end
      expect_mem(wr && tgt == TGT_RAM, tgt, xa);
      if (wr && a >= 16'hFFFD) begin
        m_slot[a - 16'hFFFD] = d;
      end
    end else if (a[7:6] == 2'd2) begin
      if (a[0]) begin
        vdp_ctrl(wr, d);
      end else begin
        vdp_data(wr, d);
      end
    end else if (a[7:6] == 2'd3) begin
      if (!wr) begin
        expect_rd(a[0] ? 8'hBF : {2'b11, ~i_buttons[2:1], ~i_buttons[6:3]});
      end
    end else if (a[7:6] == 2'd0 && !a[0] && wr) begin
      m_mem_ctrl = d;
    end else if (!wr) begin
      expect_rd(8'hFF);  // Open bus
    end
  endtask

  // ========================================
  // Bus driver
  // ========================================
  task automatic bus_access(logic iorq, logic wr, cpu_addr_t addr, cpu_data_t data);
    @(negedge cpuClock);
    i_bus_valid = 1'b1;
    i_iorq      = iorq;
    i_wr        = wr;
    i_addr      = addr;
    i_wdata     = data;
    model_apply(iorq, wr, addr, data);
  endtask

  task automatic io_wr(logic [1:0] sel, logic b0, cpu_data_t d);
    bus_access(1'b1, 1'b1, io_addr(sel, b0), d);
  endtask

  task automatic io_rd(logic [1:0] sel, logic b0);
    bus_access(1'b1, 1'b0, io_addr(sel, b0), 8'h00);
  endtask

  task automatic ctrl_pair(cpu_data_t first, cpu_data_t second);
    io_wr(2'd2, 1'b1, first);
    io_wr(2'd2, 1'b1, second);
  endtask

  task automatic data_access();
    logic wr;
    wr = rand_bits(1);
    bus_access(1'b1, wr, io_addr(2'd2, 1'b0), rand_byte());
  endtask

  // Idle the bus until every access has left the pipeline
  task automatic drain();
    int waited;
    waited = 0;
    @(negedge cpuClock);
    i_bus_valid = 1'b0;
    while (exp_q.size() != 0 || waited < 4) begin
      @(negedge cpuClock);
      waited++;
      if (waited > 100) begin
        $display("Timeout: %0d expected outputs never appeared", exp_q.size());
        $display("Result: FAILED");
        $fatal(1, "Pipeline drain timed out");
      end
    end
  endtask

  task automatic pulse_flags(logic frame, logic sprite);
    @(negedge cpuClock);
    i_frame_irq  = frame;
    i_sprite_hit = sprite;
    m_frame      = m_frame | frame;
    m_coll       = m_coll | sprite;
    @(negedge cpuClock);
    i_frame_irq  = 1'b0;
    i_sprite_hit = 1'b0;
  endtask

  task automatic check_outputs();
    check_value({test_name, " video mode"}, model_mode(), o_video_mode);
    check_value({test_name, " n_int"}, !(m_frame && m_regs[1][5]), o_n_int);
  endtask

  // Compare each valid output with the oldest expected one
  always @(negedge cpuClock) begin
    if (o_rd_valid || o_mem_valid) begin
      if (exp_q.size() == 0) begin
        $display("Output valid with no access expected to produce one");
        $display("Result: FAILED");
        $fatal(1, "Unexpected output");
      end else begin
        check_value(name_q.pop_front(), exp_q.pop_front(),
                    o_mem_valid ? {1'b1, 4'd0, o_mem_we, o_mem_target, o_mem_addr}
                                : {24'd0, o_rd_data});
      end
    end
  end

  // ========================================
  // Test sequence
  // ========================================
  initial begin
    logic [1:0] flags;
    i_bus_valid  = 1'b0;
    i_addr       = '0;
    i_wdata      = '0;
    i_wr         = 1'b0;
    i_iorq       = 1'b0;
    i_frame_irq  = 1'b0;
    i_sprite_hit = 1'b0;
    i_buttons    = '0;
    n_hard_reset = 1'b0;
    for (int i = 0; i < VDP_REG_COUNT; i++) begin
      m_regs[i] = '0;
    end
    m_slot[0]  = 8'd0;
    m_slot[1]  = 8'd1;
    m_slot[2]  = 8'd2;
    m_mem_ctrl = 8'hF7;
    m_addr     = '0;
    m_latch    = '0;
    m_second   = 1'b0;
    m_cram_sel = 1'b0;
    m_frame    = 1'b0;
    m_coll     = 1'b0;
    repeat (10) @(posedge cpuClock);
    @(negedge cpuClock);
    n_hard_reset = 1'b1;

    test_name = "reset state";
    check_outputs();
    repeat (6) bus_access(1'b0, 1'b0, low_addr(), 8'h00);  // F7 selects BIOS

    // Known VRAM and CRAM contents
    test_name = "memory fill";
    ctrl_pair(8'h00, 8'h40);
    for (int a = 0; a < VRAM_DEPTH; a++) begin
      io_wr(2'd2, 1'b0, fill_byte(a, 8'h3C));
    end
    ctrl_pair(8'h00, 8'hC0);
    for (int a = 0; a < CRAM_DEPTH; a++) begin
      io_wr(2'd2, 1'b0, fill_byte(a, 8'hA5));
    end
    drain();

    test_name = "mapper";
    repeat (4) begin
      repeat (4) bus_access(1'b0, 1'b1, 16'hFFFD + rand_bits(2) % 3, rand_byte());
      io_wr(2'd0, 1'b0, rand_byte() | 8'h08);   // Cartridge
      repeat (8) bus_access(1'b0, 1'b0, low_addr(), 8'h00);
      io_wr(2'd0, 1'b0, rand_byte() & 8'hF7);   // BIOS
      repeat (4) bus_access(1'b0, 1'b0, low_addr(), 8'h00);
    end

    test_name = "work RAM";
    repeat (16) bus_access(1'b0, rand_bits(1), 16'hC000 | rand_bits(14), rand_byte());
    drain();

    test_name = "VRAM";
    repeat (4) begin
      ctrl_pair(rand_byte(), rand_bits(7));
      repeat (16) data_access();
    end
    test_name = "CRAM";
    repeat (4) begin
      ctrl_pair(rand_byte(), 8'hC0 | rand_bits(6));
      repeat (8) data_access();
    end
    drain();

    test_name = "VDP registers";
    for (int i = 0; i < 32; i++) begin
      ctrl_pair(rand_byte(), 8'h80 | cpu_data_t'(i % 16));  // Indices 11 to 15 write no register
      drain();
      check_outputs();
    end

    test_name = "status";
    repeat (8) begin
      ctrl_pair(rand_byte(), 8'h81);  // Register 1 with a random interrupt enable
      drain();
      flags = rand_bits(2);
      pulse_flags(flags[1], flags[0]);
      check_outputs();
      io_rd(2'd2, 1'b1);
      io_rd(2'd2, 1'b1);   // Flags already cleared
      io_wr(2'd2, 1'b1, rand_byte());
      io_rd(2'd2, 1'b1);   // Drops the half-written pair
      ctrl_pair(rand_byte(), rand_bits(7));
      io_rd(2'd2, 1'b0);
      drain();
      check_outputs();
    end

    test_name = "joypads";
    repeat (8) begin
      i_buttons = rand_bits(7);
      io_rd(2'd3, 1'b0);
      io_rd(2'd3, 1'b1);
      io_rd(2'd1, rand_bits(1));
      io_rd(2'd0, 1'b1);
      io_rd(2'd0, 1'b0);
      io_wr(2'd1, rand_bits(1), rand_byte());   // PSG write has no output
      io_wr(2'd0, 1'b1, rand_byte());           // Joypad control write has no output
      drain();
    end

    drain();
    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: sim.f
sms_pkg.sv
sms_access_if.sv
sms_exec_if.sv
sms_port_decode.sv
sms_vdp_port.sv
sms_mapper_regs.sv
sms_bus_result.sv
sms_system_bus.sv
sms_system_bus_props.sv
tb_sms_system_bus.sv

// File: Bender.yml
package:
  name: sms_system_bus

sources:
  - sms_pkg.sv
  - sms_access_if.sv
  - sms_exec_if.sv
  - sms_port_decode.sv
  - sms_vdp_port.sv
  - sms_mapper_regs.sv
  - sms_bus_result.sv
  - sms_system_bus.sv
  - target: test
    files:
      - sms_system_bus_props.sv
      - tb_sms_system_bus.sv
